// ==== frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

	// Queue geometry
	localparam int IQ_SIZE = 10;                  // Slots in the instruction queue
	localparam int CNT_W = $clog2(IQ_SIZE + 1);   // Holds 0..IQ_SIZE

	// Branch tag space
	localparam int OBQ_SIZE = 8;
	localparam int BR_IDX_W = $clog2(OBQ_SIZE);   // 3 bits for 8 tags

	// Field widths
	localparam int PC_W = 64;
	localparam int IR_W = 32;
	localparam int OPC_W = 6;                     // Alpha primary opcode ir[31:26]
	localparam int REG_W = 5;

	// Alpha no-op, bis r31,r31,r31
	localparam logic [IR_W-1:0] NOOP_INST = 32'h47ff_041f;

	// r31 reads as zero, used when nothing is written
	localparam logic [REG_W-1:0] ZERO_REG = 5'd31;

	// Branch type predicted at fetch
	typedef enum logic [1:0] {
		br_none   = 2'd0,
		br_cond   = 2'd1,
		br_direct = 2'd2,
		br_ret    = 2'd3
	} br_kind_e;

	// Per-slot command from the queue control
	typedef enum logic [1:0] {
		slot_hold  = 2'd0,
		slot_load  = 2'd1,   // Take the fetch fields
		slot_shift = 2'd2,   // Take the upper neighbour
		slot_clear = 2'd3
	} slot_op_e;

	// What the decode stage registers this cycle
	typedef enum logic [1:0] {
		src_none   = 2'd0,
		src_bypass = 2'd1,   // Fetch straight to decode
		src_head   = 2'd2    // Oldest queued entry
	} head_src_e;

	// Coarse opcode classes
	typedef enum logic [2:0] {
		cls_alu    = 3'd0,
		cls_load   = 3'd1,
		cls_store  = 3'd2,
		cls_branch = 3'd3,
		cls_other  = 3'd4
	} op_class_e;

endpackage

`default_nettype wire

// ==== iq_control.sv ====
`default_nettype none

module iq_control (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          fetch_valid,         // Fetch strobe
	input  logic                          dispatch_no_hazard,  // Dispatch can take one
	input  logic                          branch_incorrect,    // Flush request
	output frontend_pkg::slot_op_e        slot_op [frontend_pkg::IQ_SIZE],
	output frontend_pkg::head_src_e       head_src,
	output logic                          queue_full,
	output logic [frontend_pkg::CNT_W-1:0] queue_count
);

	logic [frontend_pkg::CNT_W-1:0] tail;       // Number of occupied slots
	logic [frontend_pkg::CNT_W-1:0] next_tail;
	logic [frontend_pkg::CNT_W-1:0] tail_m1;    // Index of the youngest entry

	assign tail_m1 = tail - 1'b1;
	assign queue_count = tail;

	// Advisory, raised one entry early while dispatch stalls
	assign queue_full = (tail >= frontend_pkg::CNT_W'(frontend_pkg::IQ_SIZE - 1)) &&
		!dispatch_no_hazard;

	always_comb begin
		next_tail = tail;
		head_src = frontend_pkg::src_none;
		for (int i = 0; i < frontend_pkg::IQ_SIZE; i++) begin
			slot_op[i] = frontend_pkg::slot_hold;
		end

		if (branch_incorrect) begin
			// Misprediction wipes every slot, nothing goes out
			for (int i = 0; i < frontend_pkg::IQ_SIZE; i++) begin
				slot_op[i] = frontend_pkg::slot_clear;
			end
			next_tail = '0;
		end else if (fetch_valid && dispatch_no_hazard) begin
			if (tail == '0) begin
				head_src = frontend_pkg::src_bypass;  // Empty, skip the slots
			end else begin
				head_src = frontend_pkg::src_head;
				// Shift below the youngest, new entry lands in its place
				for (int i = 0; i < frontend_pkg::IQ_SIZE; i++) begin
					if (frontend_pkg::CNT_W'(i) < tail_m1) begin
						slot_op[i] = frontend_pkg::slot_shift;
					end else if (frontend_pkg::CNT_W'(i) == tail_m1) begin
						slot_op[i] = frontend_pkg::slot_load;
					end
				end
			end
		end else if (dispatch_no_hazard) begin
			if (tail != '0) begin
				head_src = frontend_pkg::src_head;
				for (int i = 0; i < frontend_pkg::IQ_SIZE - 1; i++) begin
					slot_op[i] = frontend_pkg::slot_shift;
				end
				slot_op[frontend_pkg::IQ_SIZE-1] = frontend_pkg::slot_clear; // Top empties
				next_tail = tail_m1;
			end
		end else if (fetch_valid) begin
			// Full queue drops the fetch
			if (tail != frontend_pkg::CNT_W'(frontend_pkg::IQ_SIZE)) begin
				for (int i = 0; i < frontend_pkg::IQ_SIZE; i++) begin
					if (frontend_pkg::CNT_W'(i) == tail) begin
						slot_op[i] = frontend_pkg::slot_load;
					end
				end
				next_tail = tail + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tail <= '0;
		end else begin
			tail <= next_tail;
		end
	end

endmodule

`default_nettype wire

// ==== iq_slot.sv ====
`default_nettype none

module iq_slot (
	input  logic                             clock,
	input  logic                             reset,
	input  frontend_pkg::slot_op_e           op,
	// Fetch side
	input  logic [frontend_pkg::PC_W-1:0]     fetch_npc,
	input  logic [frontend_pkg::IR_W-1:0]     fetch_ir,
	input  frontend_pkg::br_kind_e           fetch_br_kind,
	input  logic                             fetch_pred_taken,
	input  logic [frontend_pkg::PC_W-1:0]     fetch_pred_pc,
	input  logic [frontend_pkg::BR_IDX_W-1:0] fetch_br_idx,
	// Upper neighbour
	input  logic                             nb_valid,
	input  logic [frontend_pkg::PC_W-1:0]     nb_npc,
	input  logic [frontend_pkg::IR_W-1:0]     nb_ir,
	input  frontend_pkg::br_kind_e           nb_br_kind,
	input  logic                             nb_pred_taken,
	input  logic [frontend_pkg::PC_W-1:0]     nb_pred_pc,
	input  logic [frontend_pkg::BR_IDX_W-1:0] nb_br_idx,
	// Stored entry
	output logic                             valid,
	output logic [frontend_pkg::PC_W-1:0]     npc,
	output logic [frontend_pkg::IR_W-1:0]     ir,
	output frontend_pkg::br_kind_e           br_kind,
	output logic                             pred_taken,
	output logic [frontend_pkg::PC_W-1:0]     pred_pc,
	output logic [frontend_pkg::BR_IDX_W-1:0] br_idx
);

	always_ff @(posedge clock) begin
		if (reset || op == frontend_pkg::slot_clear) begin
			valid      <= 1'b0;
			npc        <= '0;
			ir         <= frontend_pkg::NOOP_INST;   // Empty slot decodes as nop
			br_kind    <= frontend_pkg::br_none;
			pred_taken <= 1'b0;
			pred_pc    <= '0;
			br_idx     <= '0;
		end else if (op == frontend_pkg::slot_load) begin
			valid      <= 1'b1;                      // Fetch is always a live entry
			npc        <= fetch_npc;
			ir         <= fetch_ir;
			br_kind    <= fetch_br_kind;
			pred_taken <= fetch_pred_taken;
			pred_pc    <= fetch_pred_pc;
			br_idx     <= fetch_br_idx;
		end else if (op == frontend_pkg::slot_shift) begin
			// Move down one toward the head
			valid      <= nb_valid;
			npc        <= nb_npc;
			ir         <= nb_ir;
			br_kind    <= nb_br_kind;
			pred_taken <= nb_pred_taken;
			pred_pc    <= nb_pred_pc;
			br_idx     <= nb_br_idx;
		end
		// slot_hold keeps everything
	end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none

module decode_stage (
	input  logic                              clock,
	input  logic                              reset,
	input  frontend_pkg::head_src_e           head_src,
	// Bypass path from fetch
	input  logic [frontend_pkg::PC_W-1:0]      fetch_npc,
	input  logic [frontend_pkg::IR_W-1:0]      fetch_ir,
	input  frontend_pkg::br_kind_e            fetch_br_kind,
	input  logic                              fetch_pred_taken,
	input  logic [frontend_pkg::PC_W-1:0]      fetch_pred_pc,
	input  logic [frontend_pkg::BR_IDX_W-1:0]  fetch_br_idx,
	// Queue head, slot 0
	input  logic                              head_valid,
	input  logic [frontend_pkg::PC_W-1:0]      head_npc,
	input  logic [frontend_pkg::IR_W-1:0]      head_ir,
	input  frontend_pkg::br_kind_e            head_br_kind,
	input  logic                              head_pred_taken,
	input  logic [frontend_pkg::PC_W-1:0]      head_pred_pc,
	input  logic [frontend_pkg::BR_IDX_W-1:0]  head_br_idx,
	// Registered dispatch
	output logic                              out_valid,
	output logic [frontend_pkg::PC_W-1:0]      out_npc,
	output logic [frontend_pkg::IR_W-1:0]      out_ir,
	output frontend_pkg::br_kind_e            out_br_kind,
	output logic                              out_pred_taken,
	output logic [frontend_pkg::PC_W-1:0]      out_pred_pc,
	output logic [frontend_pkg::BR_IDX_W-1:0]  out_br_idx,
	output frontend_pkg::op_class_e           out_op_class,
	output logic [frontend_pkg::REG_W-1:0]     out_dest_reg
);

	logic                              sel_valid;
	logic [frontend_pkg::PC_W-1:0]      sel_npc;
	logic [frontend_pkg::IR_W-1:0]      sel_ir;
	frontend_pkg::br_kind_e            sel_br_kind;
	logic                              sel_pred_taken;
	logic [frontend_pkg::PC_W-1:0]      sel_pred_pc;
	logic [frontend_pkg::BR_IDX_W-1:0]  sel_br_idx;
	logic [frontend_pkg::OPC_W-1:0]     opc;
	frontend_pkg::op_class_e           op_class;
	logic [frontend_pkg::REG_W-1:0]     dest_reg;

	// Source mux, none gives an invalid nop
	always_comb begin
		sel_valid      = 1'b0;
		sel_npc        = '0;
		sel_ir         = frontend_pkg::NOOP_INST;
		sel_br_kind    = frontend_pkg::br_none;
		sel_pred_taken = 1'b0;
		sel_pred_pc    = '0;
		sel_br_idx     = '0;
		case (head_src)
			frontend_pkg::src_bypass: begin
				sel_valid      = 1'b1;
				sel_npc        = fetch_npc;
				sel_ir         = fetch_ir;
				sel_br_kind    = fetch_br_kind;
				sel_pred_taken = fetch_pred_taken;
				sel_pred_pc    = fetch_pred_pc;
				sel_br_idx     = fetch_br_idx;
			end
			frontend_pkg::src_head: begin
				sel_valid      = head_valid;
				sel_npc        = head_npc;
				sel_ir         = head_ir;
				sel_br_kind    = head_br_kind;
				sel_pred_taken = head_pred_taken;
				sel_pred_pc    = head_pred_pc;
				sel_br_idx     = head_br_idx;
			end
			default: ;
		endcase
	end

	assign opc = sel_ir[31:26];

	// Opcode class and written register
	always_comb begin
		op_class = frontend_pkg::cls_other;
		dest_reg = frontend_pkg::ZERO_REG;
		case (opc) inside
			6'h10, 6'h11, 6'h12, 6'h13: begin
				op_class = frontend_pkg::cls_alu;
				dest_reg = sel_ir[4:0];           // rc
			end
			6'h28, 6'h29: begin
				op_class = frontend_pkg::cls_load;
				dest_reg = sel_ir[25:21];         // ra
			end
			6'h2c, 6'h2d: op_class = frontend_pkg::cls_store;
			6'h1a, 6'h30: begin
				// Jumps and br write the link into ra
				op_class = frontend_pkg::cls_branch;
				dest_reg = sel_ir[25:21];
			end
			[6'h31:6'h3f]: op_class = frontend_pkg::cls_branch;  // Conditional and bsr group
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid      <= 1'b0;
			out_npc        <= '0;
			out_ir         <= frontend_pkg::NOOP_INST;
			out_br_kind    <= frontend_pkg::br_none;
			out_pred_taken <= 1'b0;
			out_pred_pc    <= '0;
			out_br_idx     <= '0;
			out_op_class   <= frontend_pkg::cls_other;
			out_dest_reg   <= frontend_pkg::ZERO_REG;
		end else begin
			out_valid      <= sel_valid;
			out_npc        <= sel_npc;
			out_ir         <= sel_ir;
			out_br_kind    <= sel_br_kind;
			out_pred_taken <= sel_pred_taken;
			out_pred_pc    <= sel_pred_pc;
			out_br_idx     <= sel_br_idx;
			out_op_class   <= op_class;
			out_dest_reg   <= dest_reg;
		end
	end

endmodule

`default_nettype wire

// ==== inst_queue_top.sv ====
`default_nettype none

module inst_queue_top (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              fetch_valid,
	input  logic [frontend_pkg::PC_W-1:0]      fetch_npc,
	input  logic [frontend_pkg::IR_W-1:0]      fetch_ir,
	input  frontend_pkg::br_kind_e            fetch_br_kind,
	input  logic                              fetch_pred_taken,
	input  logic [frontend_pkg::PC_W-1:0]      fetch_pred_pc,
	input  logic [frontend_pkg::BR_IDX_W-1:0]  fetch_br_idx,
	input  logic                              dispatch_no_hazard,
	input  logic                              branch_incorrect,
	output logic                              queue_full,
	output logic [frontend_pkg::CNT_W-1:0]     queue_count,
	output logic                              out_valid,
	output logic [frontend_pkg::PC_W-1:0]      out_npc,
	output logic [frontend_pkg::IR_W-1:0]      out_ir,
	output frontend_pkg::br_kind_e            out_br_kind,
	output logic                              out_pred_taken,
	output logic [frontend_pkg::PC_W-1:0]      out_pred_pc,
	output logic [frontend_pkg::BR_IDX_W-1:0]  out_br_idx,
	output frontend_pkg::op_class_e           out_op_class,
	output logic [frontend_pkg::REG_W-1:0]     out_dest_reg
);

	frontend_pkg::slot_op_e            slot_op [frontend_pkg::IQ_SIZE];
	frontend_pkg::head_src_e           head_src;

	// Slot contents, index 0 is the oldest
	logic                              s_valid      [frontend_pkg::IQ_SIZE];
	logic [frontend_pkg::PC_W-1:0]      s_npc        [frontend_pkg::IQ_SIZE];
	logic [frontend_pkg::IR_W-1:0]      s_ir         [frontend_pkg::IQ_SIZE];
	frontend_pkg::br_kind_e            s_br_kind    [frontend_pkg::IQ_SIZE];
	logic                              s_pred_taken [frontend_pkg::IQ_SIZE];
	logic [frontend_pkg::PC_W-1:0]      s_pred_pc    [frontend_pkg::IQ_SIZE];
	logic [frontend_pkg::BR_IDX_W-1:0]  s_br_idx     [frontend_pkg::IQ_SIZE];

	iq_control u_control (
		.clock              (clock),
		.reset              (reset),
		.fetch_valid        (fetch_valid),
		.dispatch_no_hazard (dispatch_no_hazard),
		.branch_incorrect   (branch_incorrect),
		.slot_op            (slot_op),
		.head_src           (head_src),
		.queue_full         (queue_full),
		.queue_count        (queue_count)
	);

	for (genvar i = 0; i < frontend_pkg::IQ_SIZE; i++) begin : slot_gen
		// Top slot wraps to slot 0, never shifted
		localparam int NB = (i == frontend_pkg::IQ_SIZE - 1) ? 0 : i + 1;

		iq_slot u_slot (
			.clock            (clock),
			.reset            (reset),
			.op               (slot_op[i]),
			.fetch_npc        (fetch_npc),
			.fetch_ir         (fetch_ir),
			.fetch_br_kind    (fetch_br_kind),
			.fetch_pred_taken (fetch_pred_taken),
			.fetch_pred_pc    (fetch_pred_pc),
			.fetch_br_idx     (fetch_br_idx),
			.nb_valid         (s_valid[NB]),
			.nb_npc           (s_npc[NB]),
			.nb_ir            (s_ir[NB]),
			.nb_br_kind       (s_br_kind[NB]),
			.nb_pred_taken    (s_pred_taken[NB]),
			.nb_pred_pc       (s_pred_pc[NB]),
			.nb_br_idx        (s_br_idx[NB]),
			.valid            (s_valid[i]),
			.npc              (s_npc[i]),
			.ir               (s_ir[i]),
			.br_kind          (s_br_kind[i]),
			.pred_taken       (s_pred_taken[i]),
			.pred_pc          (s_pred_pc[i]),
			.br_idx           (s_br_idx[i])
		);
	end

	decode_stage u_decode (
		.clock            (clock),
		.reset            (reset),
		.head_src         (head_src),
		.fetch_npc        (fetch_npc),
		.fetch_ir         (fetch_ir),
		.fetch_br_kind    (fetch_br_kind),
		.fetch_pred_taken (fetch_pred_taken),
		.fetch_pred_pc    (fetch_pred_pc),
		.fetch_br_idx     (fetch_br_idx),
		.head_valid       (s_valid[0]),       // Oldest entry feeds decode
		.head_npc         (s_npc[0]),
		.head_ir          (s_ir[0]),
		.head_br_kind     (s_br_kind[0]),
		.head_pred_taken  (s_pred_taken[0]),
		.head_pred_pc     (s_pred_pc[0]),
		.head_br_idx      (s_br_idx[0]),
		.out_valid        (out_valid),
		.out_npc          (out_npc),
		.out_ir           (out_ir),
		.out_br_kind      (out_br_kind),
		.out_pred_taken   (out_pred_taken),
		.out_pred_pc      (out_pred_pc),
		.out_br_idx       (out_br_idx),
		.out_op_class     (out_op_class),
		.out_dest_reg     (out_dest_reg)
	);

endmodule

`default_nettype wire

// ==== iq_assert.sv ====
`default_nettype none

module iq_assert (
	input logic                          clock,
	input logic                          reset,
	input logic                          dispatch_no_hazard,
	input logic                          branch_incorrect,
	input logic                          queue_full,
	input logic [frontend_pkg::CNT_W-1:0] queue_count,
	input logic                          out_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	// Count bounded by the slot count
	a_count_max: assert property (@(posedge clock) disable iff (reset)
		queue_count <= frontend_pkg::CNT_W'(frontend_pkg::IQ_SIZE))
		else $error("queue_count above IQ_SIZE");

	// Stalled full queue never shrinks
	a_full_stall: assert property (@(posedge clock) disable iff (reset)
		queue_full && !branch_incorrect |=> queue_count >= $past(queue_count))
		else $error("queue shrank while queue_full was raised");

	a_flush_empty: assert property (@(posedge clock) disable iff (reset)
		branch_incorrect |=> (queue_count == '0 && !out_valid))
		else $error("flush did not empty the queue");   // Next cycle empty and quiet

	a_reset_quiet: assert property (@(posedge clock) reset |=> !out_valid)
		else $error("out_valid high right after reset");

endmodule

bind inst_queue_top iq_assert u_assert (
	.clock              (clock),
	.reset              (reset),
	.dispatch_no_hazard (dispatch_no_hazard),
	.branch_incorrect   (branch_incorrect),
	.queue_full         (queue_full),
	.queue_count        (queue_count),
	.out_valid          (out_valid)
);

`default_nettype wire

// ==== iq_tb.sv ====
`default_nettype none

module iq_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// One queued instruction as the model keeps it
	typedef struct packed {
		logic [frontend_pkg::PC_W-1:0]     npc;
		logic [frontend_pkg::IR_W-1:0]     ir;
		frontend_pkg::br_kind_e           br_kind;
		logic                             pred_taken;
		logic [frontend_pkg::PC_W-1:0]     pred_pc;
		logic [frontend_pkg::BR_IDX_W-1:0] br_idx;
	} entry_t;

	// Stimulus table row
	typedef struct {
		string name;
		int    reps;
		logic  fv;
		logic  disp;
		logic  flush;
	} step_t;

	logic                              clock;
	logic                              reset;
	logic                              fetch_valid;
	logic [frontend_pkg::PC_W-1:0]      fetch_npc;
	logic [frontend_pkg::IR_W-1:0]      fetch_ir;
	frontend_pkg::br_kind_e            fetch_br_kind;
	logic                              fetch_pred_taken;
	logic [frontend_pkg::PC_W-1:0]      fetch_pred_pc;
	logic [frontend_pkg::BR_IDX_W-1:0]  fetch_br_idx;
	logic                              dispatch_no_hazard;
	logic                              branch_incorrect;
	logic                              queue_full;
	logic [frontend_pkg::CNT_W-1:0]     queue_count;
	logic                              out_valid;
	logic [frontend_pkg::PC_W-1:0]      out_npc;
	logic [frontend_pkg::IR_W-1:0]      out_ir;
	frontend_pkg::br_kind_e            out_br_kind;
	logic                              out_pred_taken;
	logic [frontend_pkg::PC_W-1:0]      out_pred_pc;
	logic [frontend_pkg::BR_IDX_W-1:0]  out_br_idx;
	frontend_pkg::op_class_e           out_op_class;
	logic [frontend_pkg::REG_W-1:0]     out_dest_reg;

	entry_t  model_q [$];                       // Oldest at index 0
	step_t   steps [$];
	string   cur_name = "reset";
	int      mismatches = 0;
	int      timeouts = 0;
	logic [15:0] lfsr = 16'(99282);              // Seed, low 16 bits kept
	logic [frontend_pkg::PC_W-1:0] next_npc = 64'h1_2000;

	inst_queue_top dut (.*);

	always #4 clock = ~clock;                    // 8 ns period

	// x^16 + x^14 + x^13 + x^11, one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[62:0], lfsr_bit()};
		return v;
	endfunction

	// Covers every opcode class
	function automatic logic [5:0] pick_opcode(input logic [2:0] k);
		case (k)
			3'd0: return 6'h10;
			3'd1: return 6'h12;
			3'd2: return 6'h28;
			3'd3: return 6'h2c;
			3'd4: return 6'h1a;   // jmp group
			3'd5: return 6'h30;   // br
			3'd6: return 6'h39;   // beq
			default: return 6'h08; // lda, other
		endcase
	endfunction

	function automatic frontend_pkg::op_class_e class_of(input logic [31:0] ir);
		logic [5:0] opc;
		opc = ir[31:26];
		if (opc >= 6'h10 && opc <= 6'h13) return frontend_pkg::cls_alu;
		if (opc == 6'h28 || opc == 6'h29) return frontend_pkg::cls_load;
		if (opc == 6'h2c || opc == 6'h2d) return frontend_pkg::cls_store;
		if (opc == 6'h1a || opc >= 6'h30) return frontend_pkg::cls_branch;
		return frontend_pkg::cls_other;
	endfunction

	function automatic logic [4:0] dest_of(input logic [31:0] ir);
		logic [5:0] opc;
		opc = ir[31:26];
		if (opc >= 6'h10 && opc <= 6'h13) return ir[4:0];   // rc
		if (opc == 6'h28 || opc == 6'h29) return ir[25:21]; // ra
		if (opc == 6'h1a || opc == 6'h30) return ir[25:21]; // Link register
		return 5'd31;
	endfunction

	function automatic entry_t empty_entry();
		entry_t e;
		e = '0;
		e.ir = frontend_pkg::NOOP_INST;
		e.br_kind = frontend_pkg::br_none;
		return e;
	endfunction

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch in %s: %s expected %b actual %b", cur_name, what, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_count(input logic [frontend_pkg::CNT_W-1:0] exp,
		input logic [frontend_pkg::CNT_W-1:0] act);
		if (act !== exp) begin
			$display("Mismatch in %s: queue_count expected %0d actual %0d", cur_name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_word(input string what, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("Mismatch in %s: %s expected %h actual %h", cur_name, what, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_class(input frontend_pkg::op_class_e exp,
		input frontend_pkg::op_class_e act);
		if (act !== exp) begin
			$display("Mismatch in %s: out_op_class expected %s actual %s", cur_name,
				exp.name(), act.name());
			mismatches++;
		end
	endtask

	task automatic check_kind(input frontend_pkg::br_kind_e exp, input frontend_pkg::br_kind_e act);
		if (act !== exp) begin
			$display("Mismatch in %s: out_br_kind expected %s actual %s", cur_name,
				exp.name(), act.name());
			mismatches++;
		end
	endtask

	task automatic add_step(input string name, input int reps, input logic fv, input logic disp,
		input logic flush);
		step_t s;
		s.name = name;
		s.reps = reps;
		s.fv = fv;
		s.disp = disp;
		s.flush = flush;
		steps.push_back(s);
	endtask

	// Entered 1 ns after a rising edge, leaves at the same point one cycle later
	task automatic run_cycle(input logic fv, input logic disp, input logic flush);
		entry_t      fetched;
		entry_t      exp;
		logic        exp_valid;
		logic        exp_full;
		logic [63:0] r;
		fetched = empty_entry();
		if (fv) begin
			r = rand_bits(3);
			fetched.ir[31:26] = pick_opcode(r[2:0]);
			r = rand_bits(26);
			fetched.ir[25:0] = r[25:0];
			r = rand_bits(2);
			fetched.br_kind = frontend_pkg::br_kind_e'(r[1:0]);
			r = rand_bits(1);
			fetched.pred_taken = r[0];
			fetched.pred_pc = rand_bits(64);
			r = rand_bits(frontend_pkg::BR_IDX_W);
			fetched.br_idx = r[frontend_pkg::BR_IDX_W-1:0];
			fetched.npc = next_npc;
			next_npc = next_npc + 64'd4;
		end
		fetch_valid = fv;
		dispatch_no_hazard = disp;
		branch_incorrect = flush;
		fetch_npc = fetched.npc;
		fetch_ir = fetched.ir;
		fetch_br_kind = fetched.br_kind;
		fetch_pred_taken = fetched.pred_taken;
		fetch_pred_pc = fetched.pred_pc;
		fetch_br_idx = fetched.br_idx;

		// Full flag from the count before this edge
		exp_full = (model_q.size() >= frontend_pkg::IQ_SIZE - 1) && !disp;
		exp = empty_entry();
		exp_valid = 1'b0;
		if (flush) begin
			model_q.delete();
		end else if (fv && disp) begin
			exp_valid = 1'b1;
			if (model_q.size() == 0) begin
				exp = fetched;                       // Bypass
			end else begin
				exp = model_q.pop_front();
				model_q.push_back(fetched);
			end
		end else if (disp && model_q.size() != 0) begin
			exp_valid = 1'b1;
			exp = model_q.pop_front();
		end else if (fv && !disp && model_q.size() < frontend_pkg::IQ_SIZE) begin
			model_q.push_back(fetched);              // Dropped when full
		end

		#1;
		check_bit("queue_full", exp_full, queue_full);
		@(posedge clock);
		#1;
		check_bit("out_valid", exp_valid, out_valid);
		check_count(frontend_pkg::CNT_W'(model_q.size()), queue_count);
		check_word("out_npc", exp.npc, out_npc);
		check_word("out_ir", 64'(exp.ir), 64'(out_ir));
		check_word("out_pred_pc", exp.pred_pc, out_pred_pc);
		check_word("out_br_idx", 64'(exp.br_idx), 64'(out_br_idx));
		check_bit("out_pred_taken", exp.pred_taken, out_pred_taken);
		check_kind(exp.br_kind, out_br_kind);
		check_class(class_of(exp.ir), out_op_class);
		check_word("out_dest_reg", 64'(dest_of(exp.ir)), 64'(out_dest_reg));
	endtask

	task automatic finish_run();
		$display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	initial begin
		int cycles;
		clock = 1'b0;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_npc = '0;
		fetch_ir = frontend_pkg::NOOP_INST;
		fetch_br_kind = frontend_pkg::br_none;
		fetch_pred_taken = 1'b0;
		fetch_pred_pc = '0;
		fetch_br_idx = '0;
		dispatch_no_hazard = 1'b0;
		branch_incorrect = 1'b0;

		// name, repeats, fetch, dispatch, flush
		add_step("bypass", 6, 1'b1, 1'b1, 1'b0);
		add_step("fill", 9, 1'b1, 1'b0, 1'b0);
		add_step("fill_full_drop", 3, 1'b1, 1'b0, 1'b0);
		add_step("drain_part", 4, 1'b0, 1'b1, 1'b0);
		add_step("mixed", 6, 1'b1, 1'b1, 1'b0);
		add_step("fill_more", 2, 1'b1, 1'b0, 1'b0);
		add_step("flush", 1, 1'b0, 1'b0, 1'b1);
		add_step("bypass_after_flush", 3, 1'b1, 1'b1, 1'b0);
		add_step("refill", 5, 1'b1, 1'b0, 1'b0);
		add_step("flush_with_fetch", 1, 1'b1, 1'b1, 1'b1);
		add_step("refill_again", 4, 1'b1, 1'b0, 1'b0);
		add_step("mixed_again", 5, 1'b1, 1'b1, 1'b0);
		add_step("stall", 2, 1'b0, 1'b0, 1'b0);
		add_step("drain_all", 6, 1'b0, 1'b1, 1'b0);

		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		cycles = 0;
		while ((out_valid !== 1'b0 || queue_count !== '0) && cycles < 20) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (out_valid !== 1'b0 || queue_count !== '0) begin
			$display("Timeout: DUT outputs did not settle after reset");
			timeouts++;
		end else begin
			foreach (steps[k]) begin
				cur_name = steps[k].name;
				repeat (steps[k].reps) run_cycle(steps[k].fv, steps[k].disp, steps[k].flush);
			end
			// Empty whatever is left, then one idle cycle
			cur_name = "final_drain";
			cycles = 0;
			while ((model_q.size() != 0 || queue_count !== '0) &&
				cycles < 2 * frontend_pkg::IQ_SIZE) begin
				run_cycle(1'b0, 1'b1, 1'b0);
				cycles++;
			end
			if (model_q.size() != 0 || queue_count !== '0) begin
				$display("Timeout: queue did not drain to empty");
				timeouts++;
			end else begin
				run_cycle(1'b0, 1'b0, 1'b0);
			end
		end
		finish_run();
	end

endmodule

`default_nettype wire

// ==== flist.f ====
frontend_pkg.sv
iq_control.sv
iq_slot.sv
decode_stage.sv
inst_queue_top.sv
iq_assert.sv
iq_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the instruction queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module iq_tb -f flist.f \
	&& ./obj_dir/Viq_tb | tee /dev/stderr | grep "TEST PASSED" > /dev/null \
	&& echo "Simulation run succeeded" \
	|| { echo "Simulation run failed"; exit 1; }
